//--- verilog/tspp_macros.svh
/* Fixed addresses and alignment constants of the two-stage pipeline.
 * Shared by the fetch and execute stages. */
`default_nettype none

`ifndef TSPP_MACROS_SVH
`define TSPP_MACROS_SVH

// First instruction address after reset.
`define TSPP_RESET_PC     32'h0000_0000

// Every trap sends fetch here, whatever its cause.
`define TSPP_TRAP_VECTOR  32'h0000_0100

// Size of one instruction word in bytes. The sequential PC steps by this.
`define TSPP_INSN_BYTES   32'd4

// Low address bits that must be zero for a word access.
// Applies to instruction targets and to LW and SW addresses alike.
`define TSPP_ALIGN_MASK   32'h0000_0003

`endif

`default_nettype wire

//--- verilog/tspp_pkg.sv
/* Types shared by the pipeline blocks and the bench.
 * Width typedefs, trap and next-PC enums, and the stage and bus records. */
`default_nettype none

package tspp_pkg;

  typedef logic [31:0] word_t;     // Data or instruction word.
  typedef logic [31:0] addr_t;     // Byte address.
  typedef logic [4:0]  reg_idx_t;  // Register file index.

  // Trap causes, numbered as in the RISC-V machine cause register.
  typedef enum logic [3:0] {
    CAUSE_MAL_INSN  = 4'd0,
    CAUSE_ILLEGAL   = 4'd2,
    CAUSE_MAL_LOAD  = 4'd4,
    CAUSE_MAL_STORE = 4'd6,
    CAUSE_IRQ       = 4'd11
  } cause_e;

  // Where the PC comes from on the next enabled edge.
  typedef enum logic [1:0] {
    PC_SEQ,     // Next word after the current fetch.
    PC_BRANCH,  // Resolved branch or JAL target.
    PC_TRAP     // Trap vector.
  } pc_sel_e;

  typedef struct packed {
    logic  valid;
    addr_t pc;
    word_t insn;
  } fetch_t;

  // What execute tells the hazard unit about the instruction in its slot.
  typedef struct packed {
    logic  active;     // Valid instruction that has not started a data access.
    logic  dmem_busy;  // Data access still waiting for its ack.
    logic  redirect;   // Taken branch or JAL.
    addr_t target;
    logic  illegal;
    logic  mal_load;
    logic  mal_store;
    addr_t bad_addr;
    addr_t pc;
  } exe_status_t;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    reg_idx_t rd;
    word_t    wdata;
  } retire_t;

  typedef struct packed {
    logic   valid;
    cause_e cause;
    addr_t  epc;
    addr_t  badaddr;
  } trap_t;

  // Wishbone classic master outputs.
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    addr_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } wb_req_t;

  // Wishbone classic slave outputs.
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- verilog/tspp_fetch.sv
/* Fetch stage of the two-stage pipeline.
 * Holds the PC and runs the instruction-side Wishbone classic master. */
`timescale 1ns/10ps
`include "tspp_macros.svh"
`default_nettype none

module tspp_fetch import tspp_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  output wb_req_t imem_req,
  input  wb_rsp_t imem_rsp,
  input  logic    pc_en,
  input  pc_sel_e pc_sel,
  input  addr_t   branch_target,
  output fetch_t  fetch_out,
  output logic    imem_busy,
  output logic    fault_target
);

  addr_t pc_q;       // Address of the next instruction to fetch.
  addr_t adr_q;      // Address of the access on the bus, frozen until ack.
  logic  cyc_q;      // Bus cycle in progress.
  logic  discard_q;  // A redirect overtook the access in flight.
  logic  redirect;
  logic  ack;
  logic  take;
  logic  issue;

  assign redirect = pc_en & (pc_sel != PC_SEQ);
  assign ack      = cyc_q & imem_rsp.ack;
  assign take     = ack & ~discard_q;  // Acked word that still belongs to the program flow.

  // A new access starts one cycle after the PC settles. It never starts from a misaligned PC.
  assign issue = ~cyc_q & ~redirect & ~|(pc_q & `TSPP_ALIGN_MASK);

  // Alignment of the execute target. The hazard unit decides whether it matters.
  assign fault_target = |(branch_target & `TSPP_ALIGN_MASK);
  assign imem_busy    = cyc_q & ~imem_rsp.ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= `TSPP_RESET_PC;
    end else if (redirect) begin
      pc_q <= (pc_sel == PC_TRAP) ? `TSPP_TRAP_VECTOR : branch_target;
    end else if (take && pc_en) begin
      pc_q <= pc_q + `TSPP_INSN_BYTES;  // Word was accepted by the buffer.
    end
  end

  // Bus cycle control. cyc drops in the cycle after ack.
  always_ff @(posedge clk) begin
    if (reset) begin
      cyc_q     <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      if (ack) begin
        cyc_q <= 1'b0;
      end else if (issue) begin
        cyc_q <= 1'b1;
      end
      if (ack) begin
        discard_q <= 1'b0;
      end else if (redirect && cyc_q) begin
        discard_q <= 1'b1;  // Let the old access finish, then drop it.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      adr_q <= pc_q;
    end
  end

  // Read-only master. Always a full word.
  assign imem_req = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: adr_q, dat: '0, sel: 4'hf};

  assign fetch_out = '{valid: take, pc: adr_q, insn: imem_rsp.dat};

endmodule

`default_nettype wire

//--- verilog/tspp_if_ex_buffer.sv
/* IF/EX pipeline register between fetch and execute.
 * Flush empties it, stall freezes it, otherwise it takes the fetch output. */
`timescale 1ns/10ps
`default_nettype none

module tspp_if_ex_buffer import tspp_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,
  input  logic   flush,
  input  fetch_t fetch_in,
  output fetch_t fetch_out
);

  logic  valid_q;  // Slot holds a live instruction.
  addr_t pc_q;
  word_t insn_q;

  // Only the valid bit is control state. Flush beats stall.
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= fetch_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q   <= fetch_in.pc;
      insn_q <= fetch_in.insn;  // Payload is don't-care while valid is low.
    end
  end

  assign fetch_out = '{valid: valid_q, pc: pc_q, insn: insn_q};

endmodule

`default_nettype wire

//--- verilog/tspp_execute.sv
/* Execute stage of the two-stage pipeline.
 * Decodes the RV32I subset, owns the register file and runs the data Wishbone master. */
`timescale 1ns/10ps
`include "tspp_macros.svh"
`default_nettype none

module tspp_execute import tspp_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  fetch_t      insn,
  input  logic        kill,
  output wb_req_t     dmem_req,
  input  wb_rsp_t     dmem_rsp,
  output exe_status_t status,
  output retire_t     retire
);

  typedef enum logic {
    EXE_IDLE,  // Slot free or holding a fresh instruction.
    EXE_MEM    // Waiting for the data ack.
  } exe_state_e;

  exe_state_e state;
  exe_state_e state_next;

  word_t      iw;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  reg_idx_t   rd_eff;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      regs [32];
  word_t      rs1_val;
  word_t      rs2_val;
  word_t      alu_res;
  word_t      wb_data;
  addr_t      eff_addr;
  addr_t      target;
  logic       is_addi, is_add, is_sub, is_lw, is_sw, is_beq, is_bne, is_jal;
  logic       legal;
  logic       is_mem;
  logic       writes_rd;
  logic       taken;
  logic       misaligned;
  logic       first;
  logic       mem_go;
  logic       start;
  logic       mem_done;
  logic       alu_retire;
  logic       rf_we;

  // Field extraction.
  assign iw     = insn.insn;
  assign opcode = iw[6:0];
  assign funct3 = iw[14:12];
  assign funct7 = iw[31:25];
  assign rd     = iw[11:7];
  assign rs1    = iw[19:15];
  assign rs2    = iw[24:20];

  assign imm_i = {{20{iw[31]}}, iw[31:20]};
  assign imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
  assign imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
  assign imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

  // Decode of the supported instructions. Anything else is illegal.
  assign is_addi = (opcode == 7'b0010011) && (funct3 == 3'b000);
  assign is_add  = (opcode == 7'b0110011) && (funct3 == 3'b000) && (funct7 == 7'b0000000);
  assign is_sub  = (opcode == 7'b0110011) && (funct3 == 3'b000) && (funct7 == 7'b0100000);
  assign is_lw   = (opcode == 7'b0000011) && (funct3 == 3'b010);
  assign is_sw   = (opcode == 7'b0100011) && (funct3 == 3'b010);
  assign is_beq  = (opcode == 7'b1100011) && (funct3 == 3'b000);
  assign is_bne  = (opcode == 7'b1100011) && (funct3 == 3'b001);
  assign is_jal  = (opcode == 7'b1101111);

  assign legal     = is_addi | is_add | is_sub | is_lw | is_sw | is_beq | is_bne | is_jal;
  assign is_mem    = is_lw | is_sw;
  assign writes_rd = is_addi | is_add | is_sub | is_lw | is_jal;

  // Register file reads. x0 always reads zero.
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

  // ALU. JAL links the address of the following word.
  always_comb begin
    alu_res = '0;
    if (is_add) begin
      alu_res = rs1_val + rs2_val;
    end else if (is_sub) begin
      alu_res = rs1_val - rs2_val;
    end else if (is_addi) begin
      alu_res = rs1_val + imm_i;
    end else if (is_jal) begin
      alu_res = insn.pc + `TSPP_INSN_BYTES;
    end
  end

  assign eff_addr   = rs1_val + (is_sw ? imm_s : imm_i);  // Load and store address.
  assign misaligned = |(eff_addr & `TSPP_ALIGN_MASK);
  assign target     = insn.pc + (is_jal ? imm_j : imm_b);
  assign taken      = is_jal | (is_beq & (rs1_val == rs2_val)) | (is_bne & (rs1_val != rs2_val));

  // An instruction acts once, in its first cycle in the slot.
  assign first    = insn.valid & (state == EXE_IDLE);
  assign mem_go   = first & is_mem & ~misaligned;  // Aligned LW or SW ready to go.
  assign start    = mem_go & ~kill;
  assign mem_done = (state == EXE_MEM) & dmem_rsp.ack;

  always_comb begin
    state_next = state;
    case (state)
      EXE_IDLE: if (start) state_next = EXE_MEM;
      EXE_MEM:  if (dmem_rsp.ack) state_next = EXE_IDLE;
      default:  state_next = EXE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= EXE_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // The buffer is stalled during the access, so address and data stay put until ack.
  assign dmem_req = '{cyc: start | (state == EXE_MEM),
                      stb: start | (state == EXE_MEM),
                      we:  is_sw,
                      adr: eff_addr,
                      dat: rs2_val,
                      sel: 4'hf};

  // Retire. Memory instructions finish on ack, the rest in their first cycle.
  assign alu_retire = first & legal & ~is_mem & ~kill;
  assign rd_eff     = writes_rd ? rd : '0;  // Stores and branches report x0.
  assign wb_data    = mem_done ? dmem_rsp.dat : alu_res;
  assign rf_we      = retire.valid & (rd_eff != '0);

  assign retire = '{valid: alu_retire | mem_done,
                    pc:    insn.pc,
                    rd:    rd_eff,
                    wdata: (rd_eff != '0) ? wb_data : '0};

  always_ff @(posedge clk) begin
    if (rf_we) begin
      regs[rd_eff] <= wb_data;
    end
  end

  // Report to the hazard unit. None of these fields depends on kill.
  assign status = '{active:    first,
                    dmem_busy: mem_go | ((state == EXE_MEM) & ~dmem_rsp.ack),
                    redirect:  first & legal & taken,
                    target:    target,
                    illegal:   first & ~legal,
                    mal_load:  first & is_lw & misaligned,
                    mal_store: first & is_sw & misaligned,
                    bad_addr:  legal ? eff_addr : iw,  // Illegal traps report the word itself.
                    pc:        insn.pc};

endmodule

`default_nettype wire

//--- verilog/tspp_hazard_unit.sv
/* Hazard unit of the two-stage pipeline.
 * Turns execute, fetch and interrupt conditions into PC, stall, flush and trap controls. */
`timescale 1ns/10ps
`default_nettype none

module tspp_hazard_unit import tspp_pkg::*; (
  input  exe_status_t exe,
  input  logic        imem_busy,
  input  logic        fault_target,
  input  logic        irq,
  output logic        pc_en,
  output pc_sel_e     pc_sel,
  output logic        buf_stall,
  output logic        buf_flush,
  output logic        kill,
  output trap_t       trap
);

  logic   e_ex_stage;   // Exception raised by the instruction in execute.
  logic   e_f_stage;    // Jump to a misaligned target.
  logic   intr;         // Interrupt takes the execute slot.
  logic   trap_valid;
  logic   branch_jump;  // Redirect that survives the trap checks.
  cause_e cause;
  addr_t  badaddr;

  assign e_ex_stage = exe.illegal | exe.mal_load | exe.mal_store;
  assign e_f_stage  = exe.redirect & fault_target & ~e_ex_stage;

  // The interrupt needs a fresh instruction to replace and no data access in progress.
  assign intr = irq & exe.active & ~exe.dmem_busy & ~e_ex_stage & ~e_f_stage;

  assign trap_valid  = e_ex_stage | e_f_stage | intr;
  assign branch_jump = exe.redirect & ~trap_valid;

  // Execute handles its own exceptions. Kill covers the other two trap kinds.
  assign kill = e_f_stage | intr;

  assign buf_stall = exe.dmem_busy;  // Hold the slot while the data bus is busy.
  assign buf_flush = trap_valid | branch_jump;

  // A fetch in flight freezes the PC unless the flow is being redirected.
  assign pc_en  = (~imem_busy & ~buf_stall) | trap_valid | branch_jump;
  assign pc_sel = trap_valid ? PC_TRAP : (branch_jump ? PC_BRANCH : PC_SEQ);

  // Cause by priority. Execute exceptions first, then the fetch target, then the interrupt.
  always_comb begin
    cause   = CAUSE_IRQ;
    badaddr = '0;
    if (exe.illegal) begin
      cause   = CAUSE_ILLEGAL;
      badaddr = exe.bad_addr;
    end else if (exe.mal_load) begin
      cause   = CAUSE_MAL_LOAD;
      badaddr = exe.bad_addr;
    end else if (exe.mal_store) begin
      cause   = CAUSE_MAL_STORE;
      badaddr = exe.bad_addr;
    end else if (e_f_stage) begin
      cause   = CAUSE_MAL_INSN;
      badaddr = exe.target;     // The target that could not be fetched.
    end
  end

  // EPC is always the instruction in the execute slot.
  assign trap = '{valid: trap_valid, cause: cause, epc: exe.pc, badaddr: badaddr};

endmodule

`default_nettype wire

//--- verilog/tspp_top.sv
/* Top level of the two-stage RV32I-subset pipeline.
 * Fetch, IF/EX buffer and execute, steered by the hazard unit. */
`timescale 1ns/10ps
`default_nettype none

module tspp_top import tspp_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    irq,
  output wb_req_t imem_req,
  input  wb_rsp_t imem_rsp,
  output wb_req_t dmem_req,
  input  wb_rsp_t dmem_rsp,
  output retire_t retire,
  output trap_t   trap
);

  fetch_t      fetch_if;    // Fetch output into the buffer.
  fetch_t      fetch_ex;    // Buffer output into execute.
  exe_status_t exe_status;
  logic        imem_busy;
  logic        fault_target;
  logic        pc_en;
  pc_sel_e     pc_sel;
  logic        buf_stall;
  logic        buf_flush;
  logic        kill;

  tspp_fetch u_fetch (
    .clk           (clk),
    .reset         (reset),
    .imem_req      (imem_req),
    .imem_rsp      (imem_rsp),
    .pc_en         (pc_en),
    .pc_sel        (pc_sel),
    .branch_target (exe_status.target),  // Trap vector is fixed inside fetch.
    .fetch_out     (fetch_if),
    .imem_busy     (imem_busy),
    .fault_target  (fault_target)
  );

  tspp_if_ex_buffer u_buffer (
    .clk       (clk),
    .reset     (reset),
    .stall     (buf_stall),
    .flush     (buf_flush),
    .fetch_in  (fetch_if),
    .fetch_out (fetch_ex)
  );

  tspp_execute u_execute (
    .clk      (clk),
    .reset    (reset),
    .insn     (fetch_ex),
    .kill     (kill),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp),
    .status   (exe_status),
    .retire   (retire)
  );

  tspp_hazard_unit u_hazard (
    .exe          (exe_status),
    .imem_busy    (imem_busy),
    .fault_target (fault_target),
    .irq          (irq),
    .pc_en        (pc_en),
    .pc_sel       (pc_sel),
    .buf_stall    (buf_stall),
    .buf_flush    (buf_flush),
    .kill         (kill),
    .trap         (trap)
  );

endmodule

`default_nettype wire

//--- bench/tspp_assert.sv
/* Bus and trap protocol checker, bound into the pipeline top level.
 * Watches both Wishbone masters and the trap port. */
`timescale 1ns/10ps
`include "tspp_macros.svh"
`default_nettype none

module tspp_assert import tspp_pkg::*; (
  input logic    clk,
  input logic    reset,
  input wb_req_t imem_req,
  input wb_rsp_t imem_rsp,
  input wb_req_t dmem_req,
  input wb_rsp_t dmem_rsp,
  input trap_t   trap
);

  int   errors = 0;  // Failed assertions, read by the bench at the end.
  logic fetched;     // At least one instruction access was seen.
  logic trap_seen;   // A trap waits for its vector fetch.
  logic stb_q;       // Instruction stb one cycle back.

  always_ff @(posedge clk) begin
    if (reset) begin
      fetched   <= 1'b0;
      trap_seen <= 1'b0;
      stb_q     <= 1'b0;
    end else begin
      stb_q <= imem_req.stb;
      if (imem_req.stb) fetched <= 1'b1;
      if (trap.valid) begin
        trap_seen <= 1'b1;
      end else if (imem_req.stb && !stb_q) begin
        trap_seen <= 1'b0;  // The vector access has started.
      end
    end
  end

  // Strobe is only legal inside a bus cycle.
  a_imem_stb_cyc: assert property (@(posedge clk) imem_req.stb |-> imem_req.cyc)
    else begin $error("imem stb is high without cyc"); errors++; end
  a_dmem_stb_cyc: assert property (@(posedge clk) dmem_req.stb |-> dmem_req.cyc)
    else begin $error("dmem stb is high without cyc"); errors++; end

  // Request fields hold until the slave acks.
  a_imem_hold: assert property (@(posedge clk) disable iff (reset)
    imem_req.stb && !imem_rsp.ack |=> imem_req.stb &&
      $stable({imem_req.we, imem_req.adr, imem_req.dat, imem_req.sel}))
    else begin $error("imem request changed before ack"); errors++; end
  a_dmem_hold: assert property (@(posedge clk) disable iff (reset)
    dmem_req.stb && !dmem_rsp.ack |=> dmem_req.stb &&
      $stable({dmem_req.we, dmem_req.adr, dmem_req.dat, dmem_req.sel}))
    else begin $error("dmem request changed before ack"); errors++; end

  // Both masters move whole words, and the instruction side only reads.
  a_imem_read: assert property (@(posedge clk) disable iff (reset)
    imem_req.stb |-> {imem_req.we, imem_req.sel} == 5'h0f)
    else begin
      $error("ERR imem_req we,sel got %h exp %h", $sampled({imem_req.we, imem_req.sel}), 5'h0f);
      errors++;
    end
  a_dmem_word: assert property (@(posedge clk) disable iff (reset)
    dmem_req.stb |-> dmem_req.sel == 4'hf)
    else begin
      $error("ERR dmem_req.sel got %h exp %h", $sampled(dmem_req.sel), 4'hf);
      errors++;
    end

  // Both buses are idle in the cycle after a reset cycle.
  a_reset_idle: assert property (@(posedge clk) reset |=> !imem_req.cyc && !dmem_req.cyc)
    else begin $error("bus cycle open right after reset"); errors++; end

  a_first_fetch: assert property (@(posedge clk) disable iff (reset)
    imem_req.stb && !fetched |-> imem_req.adr == `TSPP_RESET_PC)
    else begin
      $error("ERR imem_req.adr got %h exp %h", $sampled(imem_req.adr), `TSPP_RESET_PC);
      errors++;
    end

  // A misaligned LW or SW must never reach the data bus.
  a_no_mal_access: assert property (@(posedge clk) disable iff (reset)
    trap.valid && (trap.cause == CAUSE_MAL_LOAD || trap.cause == CAUSE_MAL_STORE)
      |-> !dmem_req.cyc)
    else begin $error("misaligned data access opened a dmem cycle"); errors++; end

  a_trap_pulse: assert property (@(posedge clk) disable iff (reset)
    trap.valid |=> !trap.valid)
    else begin $error("trap valid lasted more than one cycle"); errors++; end

  // The first new fetch after a trap goes to the vector.
  a_vector_fetch: assert property (@(posedge clk) disable iff (reset)
    imem_req.stb && !stb_q && trap_seen |-> imem_req.adr == `TSPP_TRAP_VECTOR)
    else begin
      $error("ERR imem_req.adr got %h exp %h", $sampled(imem_req.adr), `TSPP_TRAP_VECTOR);
      errors++;
    end

endmodule

bind tspp_top tspp_assert u_assert (
  .clk      (clk),
  .reset    (reset),
  .imem_req (imem_req),
  .imem_rsp (imem_rsp),
  .dmem_req (dmem_req),
  .dmem_rsp (dmem_rsp),
  .trap     (trap)
);

`default_nettype wire

//--- bench/tspp_tb.sv
/* Testbench for the two-stage pipeline.
 * Wishbone memories with random wait states and an instruction-level reference model. */
`timescale 1ns/10ps
`include "tspp_macros.svh"
`default_nettype none

module tspp_tb import tspp_pkg::*; ();

  localparam int    PROG_LEN = 64;  // Upper bound on instructions executed, handler passes included.
  localparam time   TIMEOUT  = PROG_LEN * 8 * 40;
  localparam addr_t R1 = 32'h48, R2 = 32'h4c, R3 = 32'h50, R4 = 32'h54, R5 = 32'h6c;
  localparam addr_t DONE_PC = 32'h78;

  logic    clk;
  logic    reset;
  logic    irq;
  wb_req_t imem_req;
  wb_rsp_t imem_rsp;
  wb_req_t dmem_req;
  wb_rsp_t dmem_rsp;
  retire_t retire;
  trap_t   trap;

  word_t imem [256];
  word_t dmem [256];
  logic [31:0] i_rng = 32'd73;  // LCG states of the two slaves.
  logic [31:0] d_rng;
  int    i_wait, d_wait;
  addr_t i_adr, d_adr;
  logic  d_we;
  word_t d_dat;
  int    errors = 0;
  int    total;

  // Reference model state.
  word_t    m_regs [32];
  word_t    m_dmem [256];
  addr_t    m_pc;
  int       trap_count = 0;
  word_t    cur, a_val, b_val, imm_i, imm_s, imm_b, imm_j, val;
  addr_t    maddr, jump, exp_bad, exp_next;
  logic     exp_trap, exp_store, wr;
  cause_e   exp_cause;
  reg_idx_t exp_rd;
  word_t    exp_wdata;

  tspp_top u_dut (
    .clk (clk), .reset (reset), .irq (irq),
    .imem_req (imem_req), .imem_rsp (imem_rsp),
    .dmem_req (dmem_req), .dmem_rsp (dmem_rsp),
    .retire (retire), .trap (trap)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return (a * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;  // Every address bit changes the word.
  endfunction

  // RV32I encoders for the program.
  function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
                                 input logic [6:0] op);
    logic [31:0] im;
    im = imm;
    return {im[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'h33};
  endfunction

  function automatic word_t enc_sw(input int rs2, input int rs1, input int imm);
    logic [31:0] im;
    im = imm;
    return {im[11:5], rs2[4:0], rs1[4:0], 3'b010, im[4:0], 7'h23};
  endfunction

  function automatic word_t enc_b(input int f3, input int rs1, input int rs2, input int off);
    logic [31:0] im;
    im = off;
    return {im[12], im[10:5], rs2[4:0], rs1[4:0], f3[2:0], im[4:1], im[11], 7'h63};
  endfunction

  function automatic word_t enc_jal(input int rd, input int off);
    logic [31:0] im;
    im = off;
    return {im[20], im[10:1], im[11], im[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic place(input addr_t a, input word_t w);
    imem[a[9:2]] = w;
  endtask

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      imem[i]   = 32'h0;  // Opcode zero decodes as illegal.
      dmem[i]   = fill_word(i * 4);
      m_dmem[i] = fill_word(i * 4);
    end
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    place(32'h00, enc_i(1, 0, 0, 20, 7'h13));    // Constants for the handler.
    place(32'h04, enc_i(2, 0, 0, 21, 7'h13));
    place(32'h08, enc_i(3, 0, 0, 22, 7'h13));
    place(32'h0c, enc_i(4, 0, 0, 23, 7'h13));
    place(32'h10, enc_i(0, 0, 0, 30, 7'h13));    // Trap counter.
    place(32'h14, enc_i(100, 0, 0, 5, 7'h13));
    place(32'h18, enc_i(-7, 0, 0, 6, 7'h13));
    place(32'h1c, enc_r(0, 6, 5, 7));
    place(32'h20, enc_r(32, 6, 5, 8));
    place(32'h24, enc_sw(7, 0, 16));
    place(32'h28, enc_i(16, 0, 2, 9, 7'h03));
    place(32'h2c, enc_i(32, 0, 2, 10, 7'h03));   // Reads the fill pattern.
    place(32'h30, enc_b(0, 9, 7, 8));            // Taken BEQ.
    place(32'h34, enc_i(1, 0, 0, 11, 7'h13));
    place(32'h38, enc_b(1, 9, 7, 8));            // Untaken BNE.
    place(32'h3c, enc_jal(1, 8));
    place(32'h40, enc_i(2, 0, 0, 11, 7'h13));
    place(32'h44, 32'hffff_ffff);                // Illegal word.
    place(R1,     enc_i(2, 0, 2, 12, 7'h03));    // Misaligned LW.
    place(R2,     enc_sw(7, 5, 5));              // Misaligned SW.
    place(R3,     enc_jal(1, 2));                // JAL to a half-word target.
    place(R4,     enc_i(0, 0, 0, 13, 7'h13));
    for (int i = 0; i < 4; i++) place(32'h58 + 4 * i, enc_i(1, 13, 0, 13, 7'h13));
    place(32'h68, enc_r(0, 5, 13, 14));
    place(R5,     enc_sw(13, 0, 36));
    place(32'h70, enc_i(36, 0, 2, 15, 7'h03));
    place(32'h74, enc_r(0, 10, 15, 16));
    place(DONE_PC, enc_jal(0, 0));               // Spin here at the end.
    // Handler counts traps in x30 and returns to the matching resume point.
    place(32'h100, enc_i(1, 30, 0, 30, 7'h13));
    place(32'h104, enc_b(0, 30, 20, R1 - 32'h104));
    place(32'h108, enc_b(0, 30, 21, R2 - 32'h108));
    place(32'h10c, enc_b(0, 30, 22, R3 - 32'h10c));
    place(32'h110, enc_b(0, 30, 23, R4 - 32'h110));
    place(32'h114, enc_jal(0, R5 - 32'h114));
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Instruction memory. Ack comes after 0 to 3 wait states.
  always @(posedge clk) begin
    if (reset || !imem_req.stb || imem_rsp.ack) begin
      i_wait = -1;
      #2 imem_rsp.ack = 1'b0;
    end else begin
      if (i_wait < 0) begin
        i_rng  = lcg_next(i_rng);
        i_wait = i_rng[31:30];
      end
      if (i_wait == 0) begin
        i_adr = imem_req.adr;  // Captured before the edge's updates land.
        #2 imem_rsp = '{ack: 1'b1, dat: imem[i_adr[9:2]]};
      end else begin
        i_wait--;
      end
    end
  end

  // Data memory. Writes land on the ack.
  always @(posedge clk) begin
    if (reset || !dmem_req.stb || dmem_rsp.ack) begin
      d_wait = -1;
      #2 dmem_rsp.ack = 1'b0;
    end else begin
      if (d_wait < 0) begin
        d_rng  = lcg_next(d_rng);
        d_wait = d_rng[31:30];
      end
      if (d_wait == 0) begin
        d_adr = dmem_req.adr;
        d_we  = dmem_req.we;
        d_dat = dmem_req.dat;
        #2 dmem_rsp = '{ack: 1'b1, dat: dmem[d_adr[9:2]]};
        if (d_we) dmem[d_adr[9:2]] = d_dat;
      end else begin
        d_wait--;
      end
    end
  end

  // Reference model. Works out what the instruction at m_pc must do.
  always_comb begin
    cur       = imem[m_pc[9:2]];
    a_val     = m_regs[cur[19:15]];
    b_val     = m_regs[cur[24:20]];
    imm_i     = {{20{cur[31]}}, cur[31:20]};
    imm_s     = {{20{cur[31]}}, cur[31:25], cur[11:7]};
    imm_b     = {{19{cur[31]}}, cur[31], cur[7], cur[30:25], cur[11:8], 1'b0};
    imm_j     = {{11{cur[31]}}, cur[31], cur[19:12], cur[20], cur[30:21], 1'b0};
    maddr     = a_val + ((cur[6:0] == 7'h23) ? imm_s : imm_i);
    jump      = m_pc + ((cur[6:0] == 7'h6f) ? imm_j : imm_b);
    exp_trap  = 1'b0;
    exp_cause = CAUSE_ILLEGAL;
    exp_bad   = cur;  // An illegal word reports itself.
    exp_next  = m_pc + 4;
    exp_store = 1'b0;
    wr        = 1'b0;
    val       = '0;
    case (cur[6:0])
      7'h13: if (cur[14:12] == 3'd0) begin
        wr  = 1'b1;
        val = a_val + imm_i;
      end else exp_trap = 1'b1;
      7'h33: if (cur[14:12] == 3'd0 && cur[31:25] == 7'h00) begin
        wr  = 1'b1;
        val = a_val + b_val;
      end else if (cur[14:12] == 3'd0 && cur[31:25] == 7'h20) begin
        wr  = 1'b1;
        val = a_val - b_val;
      end else exp_trap = 1'b1;
      7'h03: if (cur[14:12] != 3'd2) exp_trap = 1'b1;
        else if (maddr[1:0] != 2'd0) begin
          exp_trap  = 1'b1;
          exp_cause = CAUSE_MAL_LOAD;
          exp_bad   = maddr;
        end else begin
          wr  = 1'b1;
          val = m_dmem[maddr[9:2]];
        end
      7'h23: if (cur[14:12] != 3'd2) exp_trap = 1'b1;
        else if (maddr[1:0] != 2'd0) begin
          exp_trap  = 1'b1;
          exp_cause = CAUSE_MAL_STORE;
          exp_bad   = maddr;
        end else exp_store = 1'b1;
      7'h63: if (cur[14:12] > 3'd1) exp_trap = 1'b1;
        else if ((cur[14:12] == 3'd0) == (a_val == b_val)) begin
          if (jump[1:0] != 2'd0) begin
            exp_trap  = 1'b1;
            exp_cause = CAUSE_MAL_INSN;
            exp_bad   = jump;
          end else exp_next = jump;
        end
      7'h6f: if (jump[1:0] != 2'd0) begin
        exp_trap  = 1'b1;
        exp_cause = CAUSE_MAL_INSN;
        exp_bad   = jump;
      end else begin
        wr       = 1'b1;
        val      = m_pc + 4;  // Link address.
        exp_next = jump;
      end
      default: exp_trap = 1'b1;
    endcase
    exp_rd    = wr ? cur[11:7] : 5'd0;
    exp_wdata = (exp_rd != 5'd0) ? val : '0;
  end

  // The model steps on each retire or trap that the DUT reports.
  always @(posedge clk) begin
    if (reset) begin
      m_pc <= `TSPP_RESET_PC;
    end else if (trap.valid) begin
      m_pc       <= `TSPP_TRAP_VECTOR;
      trap_count <= trap_count + 1;
    end else if (retire.valid) begin
      if (exp_rd != 5'd0) m_regs[exp_rd] <= exp_wdata;
      if (exp_store) m_dmem[maddr[9:2]] <= b_val;
      m_pc <= exp_next;
    end
  end

  a_one_event: assert property (@(posedge clk) disable iff (reset)
    !(retire.valid && trap.valid))
    else begin $error("retire and trap in the same cycle"); errors++; end
  a_retire_ok: assert property (@(posedge clk) disable iff (reset)
    retire.valid |-> !exp_trap)
    else begin $error("an instruction that must trap was retired"); errors++; end
  a_retire_pc: assert property (@(posedge clk) disable iff (reset)
    retire.valid |-> retire.pc == m_pc)
    else begin
      $display("ERR retire.pc got %h exp %h", $sampled(retire.pc), $sampled(m_pc));
      errors++;
    end
  a_retire_rd: assert property (@(posedge clk) disable iff (reset)
    retire.valid |-> retire.rd == exp_rd)
    else begin
      $display("ERR retire.rd got %h exp %h", $sampled(retire.rd), $sampled(exp_rd));
      errors++;
    end
  a_retire_wdata: assert property (@(posedge clk) disable iff (reset)
    retire.valid |-> retire.wdata == exp_wdata)
    else begin
      $display("ERR retire.wdata got %h exp %h", $sampled(retire.wdata), $sampled(exp_wdata));
      errors++;
    end
  a_trap_epc: assert property (@(posedge clk) disable iff (reset)
    trap.valid |-> trap.epc == m_pc)
    else begin
      $display("ERR trap.epc got %h exp %h", $sampled(trap.epc), $sampled(m_pc));
      errors++;
    end
  // Synchronous traps must match the model. An interrupt needs irq high.
  a_trap_cause: assert property (@(posedge clk) disable iff (reset)
    trap.valid |-> ((trap.cause == CAUSE_IRQ) ? (irq && !exp_trap)
                                              : (exp_trap && trap.cause == exp_cause)))
    else begin
      $display("ERR trap.cause got %h exp %h", $sampled(trap.cause), $sampled(exp_cause));
      errors++;
    end
  a_trap_bad: assert property (@(posedge clk) disable iff (reset)
    trap.valid && trap.cause != CAUSE_IRQ |-> trap.badaddr == exp_bad)
    else begin
      $display("ERR trap.badaddr got %h exp %h", $sampled(trap.badaddr), $sampled(exp_bad));
      errors++;
    end

  // Raise irq once the arithmetic block starts, drop it after the trap.
  initial begin
    irq = 1'b0;
    wait (reset === 1'b0);
    do @(posedge clk); while (!(retire.valid && retire.pc == R4));
    #2 irq = 1'b1;
    do @(posedge clk); while (!trap.valid);
    #2 irq = 1'b0;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired after %0t with the program unfinished", $time);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    reset    = 1'b1;
    imem_rsp = '0;
    dmem_rsp = '0;
    d_rng    = lcg_next(32'd73);  // Data side runs one step ahead of the fetch side.
    load_program();
    repeat (3) @(posedge clk);
    #2 reset = 1'b0;
    do @(posedge clk); while (!(retire.valid && retire.pc == DONE_PC));
    @(posedge clk);
    assert (trap_count == 5)
      else begin $error("expected five traps but saw %0d", trap_count); errors++; end
    total = errors + u_dut.u_assert.errors;
    $display("checks done: %0d model errors, %0d bus errors, %0d traps",
             errors, u_dut.u_assert.errors, trap_count);
    if (total == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/tspp_pkg.sv
verilog/tspp_fetch.sv
verilog/tspp_if_ex_buffer.sv
verilog/tspp_execute.sv
verilog/tspp_hazard_unit.sv
verilog/tspp_top.sv
bench/tspp_assert.sv
bench/tspp_tb.sv
